// ==== src/lsu_pkg.sv ====
/*
  shared types for the load/store unit
  holds the bus widths, the outstanding transfer limit, the access size and
  load fill encodings, and the request and bus payload structs
  import it inside a module body, or use scoped names in port lists
*/

package lsu_pkg;

  //////////////////////////////////////////////////
  // widths and limits
  //////////////////////////////////////////////////

  localparam int LSU_XLEN   = 32;            // data and address width
  localparam int LSU_NBYTES = LSU_XLEN / 8;  // byte lanes per word
  localparam int LSU_DEPTH  = 2;             // max outstanding bus transfers

  typedef logic [LSU_XLEN-1:0]   word_t;
  typedef logic [LSU_NBYTES-1:0] be_t;
  typedef logic [$clog2(LSU_DEPTH+1)-1:0] cnt_t;  // counts 0..LSU_DEPTH

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } size_e;

  // how the upper bits of a narrow load are filled
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,
    EXT_SIGN = 2'b01,
    EXT_ONES = 2'b10
  } ext_e;

  //////////////////////////////////////////////////
  // payload structs
  //////////////////////////////////////////////////

  // request from the execute stage
  typedef struct packed {
    logic  we;        // 1 = store
    size_e size;
    ext_e  ext;
    logic  use_incr;  // address = op_a + op_b
    word_t op_a;
    word_t op_b;
    word_t wdata;     // store data, low bytes first
  } lsu_req_t;

  // address phase of the data bus
  typedef struct packed {
    word_t addr;
    logic  we;
    be_t   be;
    word_t wdata;     // already rotated into byte lanes
  } obi_req_t;

  // what writeback needs to align the response
  typedef struct packed {
    logic       we;
    size_e      size;
    ext_e       ext;
    logic [1:0] offset;  // byte offset of the access
  } wb_ctrl_t;

endpackage

// ==== src/lsu_store_align.sv ====
/*
  address phase formation for the load/store unit
  computes the bus address, the byte enables and the store data placed
  in its byte lanes, all combinational from the execute request
  offset_o is handed on to writeback for load alignment
*/

`timescale 1ns/1ps

module lsu_store_align (
  input  lsu_pkg::lsu_req_t req_i,
  output lsu_pkg::obi_req_t bus_o,
  output logic [1:0]        offset_o
);

  import lsu_pkg::*;

  word_t      addr;
  logic [1:0] offset;
  be_t        be;
  word_t      wdata_rot;

  //////////////////////////////////////////////////
  // address
  //////////////////////////////////////////////////

  // base plus increment, or base alone
  assign addr   = req_i.use_incr ? (req_i.op_a + req_i.op_b) : req_i.op_a;
  assign offset = addr[1:0];  // alignment is the core's job

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  always_comb
  begin
    case (req_i.size)
      SIZE_WORD: be = 4'b1111;
      SIZE_HALF: be = 4'b0011 << offset;  // offset 0 or 2
      SIZE_BYTE: be = 4'b0001 << offset;
      default:   be = 4'b0000;            // unused size code, nothing written
    endcase
  end

  // rotate left by the byte offset, low byte lands on first enabled lane
  always_comb
  begin
    case (offset)
      2'b00: wdata_rot = req_i.wdata;
      2'b01: wdata_rot = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10: wdata_rot = {req_i.wdata[15:0], req_i.wdata[31:16]};
      2'b11: wdata_rot = {req_i.wdata[7:0],  req_i.wdata[31:8]};
      default: wdata_rot = req_i.wdata;
    endcase
  end

  // bus payload, valid whenever the request is
  assign bus_o.addr  = addr;
  assign bus_o.we    = req_i.we;
  assign bus_o.be    = be;
  assign bus_o.wdata = wdata_rot;

  assign offset_o = offset;

endmodule

// ==== src/lsu_load_align.sv ====
/*
  writeback side of the load/store unit
  latches the access control when a request leaves execute, then on each
  response picks the addressed lane and fills the upper bits
  rdata_o is live during rvalid and otherwise holds the last load result
*/

`timescale 1ns/1ps

module lsu_load_align (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ctrl_update_i,  // request consumed this edge
  input  lsu_pkg::lsu_req_t req_i,
  input  logic [1:0]        offset_i,
  input  logic              rvalid_i,
  input  lsu_pkg::word_t    rdata_i,
  output lsu_pkg::word_t    rdata_o
);

  import lsu_pkg::*;

  wb_ctrl_t wb_ctrl_q;
  word_t    lane_data;   // response shifted down to the addressed lane
  word_t    rdata_ext;   // aligned and filled result
  word_t    rdata_q;     // last load result

  //////////////////////////////////////////////////
  // writeback control register
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_ctrl_q <= '0;
    end
    else if (ctrl_update_i)
    begin
      wb_ctrl_q.we     <= req_i.we;
      wb_ctrl_q.size   <= req_i.size;
      wb_ctrl_q.ext    <= req_i.ext;
      wb_ctrl_q.offset <= offset_i;
    end
  end

  //////////////////////////////////////////////////
  // lane select and fill
  //////////////////////////////////////////////////

  // move addressed byte or halfword down to bit 0
  assign lane_data = rdata_i >> {wb_ctrl_q.offset, 3'b000};

  always_comb
  begin
    case (wb_ctrl_q.size)
      SIZE_HALF:
      begin
        case (wb_ctrl_q.ext)
          EXT_SIGN: rdata_ext = {{16{lane_data[15]}}, lane_data[15:0]};
          EXT_ONES: rdata_ext = {16'hffff, lane_data[15:0]};
          default:  rdata_ext = {16'h0000, lane_data[15:0]};  // zero fill
        endcase
      end
      SIZE_BYTE:
      begin
        case (wb_ctrl_q.ext)
          EXT_SIGN: rdata_ext = {{24{lane_data[7]}}, lane_data[7:0]};
          EXT_ONES: rdata_ext = {24'hff_ffff, lane_data[7:0]};
          default:  rdata_ext = {24'h00_0000, lane_data[7:0]};
        endcase
      end
      default:
      begin
        rdata_ext = rdata_i;  // words pass as they are
      end
    endcase
  end

  //////////////////////////////////////////////////
  // held result
  //////////////////////////////////////////////////

  // store responses leave the held value alone
  always_ff @(posedge clk)
  begin
    if (rvalid_i && !wb_ctrl_q.we)
    begin
      rdata_q <= rdata_ext;
    end
  end

  assign rdata_o = rvalid_i ? rdata_ext : rdata_q;

endmodule

// ==== src/lsu_txn_ctrl.sv ====
/*
  transfer control for the load/store unit
  counts bus transfers between grant and rvalid, gates the bus request
  below the outstanding limit, and derives the execute and writeback
  handshakes plus busy from that count
*/

`timescale 1ns/1ps

module lsu_txn_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic req_valid_i,    // execute stage has a load or store
  input  logic gnt_i,
  input  logic rvalid_i,
  output logic data_req_o,
  output logic ctrl_update_o,  // request leaves execute
  output logic ready_ex_o,
  output logic ready_wb_o,
  output logic busy_o
);

  import lsu_pkg::*;

  cnt_t cnt_q;
  cnt_t cnt_d;
  logic count_up;    // transfer accepted on the bus
  logic count_down;  // response returned

  //////////////////////////////////////////////////
  // bus request and counter
  //////////////////////////////////////////////////

  // no path from rvalid to req, a full counter simply blocks
  assign data_req_o = req_valid_i && (cnt_q < cnt_t'(LSU_DEPTH));

  assign count_up   = data_req_o && gnt_i;
  assign count_down = rvalid_i;

  always_comb
  begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + cnt_t'(1);
      2'b01:   cnt_d = cnt_q - cnt_t'(1);
      default: cnt_d = cnt_q;  // both or neither
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q <= '0;
    end
    else
    begin
      cnt_q <= cnt_d;
    end
  end

  //////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////

  // with WB occupied, EX and WB advance together on rvalid
  always_comb
  begin
    if (!req_valid_i)
      ready_ex_o = 1'b1;
    else if (cnt_q == cnt_t'(0))
      ready_ex_o = count_up;
    else if (cnt_q == cnt_t'(1))
      ready_ex_o = count_up && rvalid_i;
    else
      ready_ex_o = rvalid_i;  // full, no grant possible
  end

  assign ready_wb_o    = (cnt_q == cnt_t'(0)) ? 1'b1 : rvalid_i;
  assign ctrl_update_o = req_valid_i && ready_ex_o;
  assign busy_o        = (cnt_q != cnt_t'(0)) || data_req_o;

endmodule

// ==== src/lsu_top.sv ====
/*
  load/store unit top level
  connects the execute request to the bus through the store aligner,
  the transfer controller and the load aligner
  up to two bus transfers may be outstanding
*/

`timescale 1ns/1ps

module lsu_top (
  input  logic              clk,
  input  logic              rst_n,
  // execute and writeback side
  input  logic              req_valid_i,
  input  lsu_pkg::lsu_req_t req_i,
  output logic              ready_ex_o,
  output logic              ready_wb_o,
  output lsu_pkg::word_t    rdata_o,
  output logic              busy_o,
  // data bus
  output logic              data_req_o,
  output lsu_pkg::obi_req_t data_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  lsu_pkg::word_t    data_rdata_i
);

  logic [1:0] offset;       // byte offset of the current request
  logic       ctrl_update;  // request handed to writeback

  // address, byte enables and lane placed store data
  lsu_store_align store_align_inst (
    .req_i    (req_i),
    .bus_o    (data_o),
    .offset_o (offset)
  );

  lsu_txn_ctrl txn_ctrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .gnt_i         (data_gnt_i),
    .rvalid_i      (data_rvalid_i),
    .data_req_o    (data_req_o),
    .ctrl_update_o (ctrl_update),
    .ready_ex_o    (ready_ex_o),
    .ready_wb_o    (ready_wb_o),
    .busy_o        (busy_o)
  );

  // response alignment and fill
  lsu_load_align load_align_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_update_i (ctrl_update),
    .req_i         (req_i),
    .offset_i      (offset),
    .rvalid_i      (data_rvalid_i),
    .rdata_i       (data_rdata_i),
    .rdata_o       (rdata_o)
  );

endmodule

// ==== dv/lsu_tb_mem.sv ====
/*
  memory model for the load/store unit testbench
  16 words on the data bus, grants after 0 to 2 random cycles and answers
  each transfer 1 to 3 cycles after its grant, in order
  stores write only the enabled byte lanes
*/

`timescale 1ns/1ps

module lsu_tb_mem (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_i,
  input  lsu_pkg::obi_req_t bus_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output lsu_pkg::word_t    rdata_o
);

  import lsu_pkg::*;

  word_t mem_q [16];
  int    wait_q;      // cycles left before the next grant
  int    cyc_q;       // local cycle count for response scheduling
  int    last_due_q;  // keeps responses one per cycle and in order
  int    due_q [$];
  word_t data_q [$];

  initial
  begin
    for (int i = 0; i < 16; i++)
    begin
      mem_q[i] = 32'h9e37_79b9 * (i + 1);  // every word differs
    end
  end

  assign gnt_o = req_i && (wait_q == 0);

  always @(posedge clk, negedge rst_n)
  begin
    logic [3:0] widx;
    int         due;
    if (!rst_n)
    begin
      wait_q   <= 0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      cyc_q      = 0;
      last_due_q = -1;
      due_q.delete();
      data_q.delete();
    end
    else
    begin
      if (req_i && gnt_o)
      begin
        widx = bus_i.addr[5:2];
        for (int l = 0; l < 4; l++)
        begin
          if (bus_i.we && bus_i.be[l])
            mem_q[widx][8*l +: 8] = bus_i.wdata[8*l +: 8];
        end
        data_q.push_back(bus_i.we ? 32'h0 : mem_q[widx]);
        due = cyc_q + $urandom_range(2, 0);  // 1..3 cycles after grant
        if (due <= last_due_q)
          due = last_due_q + 1;
        due_q.push_back(due);
        last_due_q = due;
        wait_q <= $urandom_range(2, 0);
      end
      else if (req_i && wait_q > 0)
      begin
        wait_q <= wait_q - 1;
      end
      if (due_q.size() != 0 && due_q[0] <= cyc_q)
      begin
        rvalid_o <= 1'b1;
        rdata_o  <= data_q.pop_front();
        void'(due_q.pop_front());
      end
      else
      begin
        rvalid_o <= 1'b0;
        rdata_o  <= $urandom;  // junk outside rvalid
      end
      cyc_q = cyc_q + 1;
    end
  end

endmodule

// ==== dv/lsu_tb.sv ====
/*
  testbench for the load/store unit
  runs a table of stores and loads through lsu_top against the memory
  model, checks bus payloads at grant, load results and the held value,
  and watches the outstanding count, busy, ready and request stability
*/

`timescale 1ns/1ps

module lsu_tb;

  import lsu_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int N_ENTRIES  = 17;

  typedef struct packed {
    logic  we;
    size_e size;
    ext_e  ext;
    logic  use_incr;
    word_t op_a;
    word_t op_b;
    word_t wdata;
    word_t exp_addr;
    be_t   exp_be;
    word_t exp_wdata;  // store data as it must appear on the bus
    word_t exp_rdata;
  } entry_t;

  logic     clk;
  logic     rst_n;
  logic     req_valid;
  lsu_req_t req;
  logic     ready_ex;
  logic     ready_wb;
  logic     busy;
  logic     data_req;
  logic     gnt;
  logic     rvalid;
  word_t    rdata;
  word_t    mem_rdata;
  obi_req_t data;

  entry_t   tab [N_ENTRIES];
  int       err_entry [N_ENTRIES];
  int       n_tab;
  int       cur;          // entry currently driven
  int       errors;
  int       n_pass;
  int       n_fail;
  int       out_cnt;      // grants minus rvalids seen so far
  int       pend_q [$];   // entries waiting for their response
  int       granted_idx;  // last entry granted on the bus
  logic     running;
  logic     hold_q;       // request was pending without grant
  obi_req_t held;
  logic     have_load;
  word_t    last_load;
  int       last_idx;

  lsu_top lsu_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid),
    .req_i         (req),
    .ready_ex_o    (ready_ex),
    .ready_wb_o    (ready_wb),
    .rdata_o       (rdata),
    .busy_o        (busy),
    .data_req_o    (data_req),
    .data_o        (data),
    .data_gnt_i    (gnt),
    .data_rvalid_i (rvalid),
    .data_rdata_i  (mem_rdata)
  );

  lsu_tb_mem lsu_tb_mem_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (data_req),
    .bus_i    (data),
    .gnt_o    (gnt),
    .rvalid_o (rvalid),
    .rdata_o  (mem_rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // stimulus table and expected values
  //////////////////////////////////////////////////

  function automatic void add_entry(logic we, size_e size, ext_e ext, logic incr,
                                    word_t a, word_t b, word_t wd);
    tab[n_tab] = '0;
    tab[n_tab].we       = we;
    tab[n_tab].size     = size;
    tab[n_tab].ext      = ext;
    tab[n_tab].use_incr = incr;
    tab[n_tab].op_a     = a;
    tab[n_tab].op_b     = b;
    tab[n_tab].wdata    = wd;
    n_tab++;
  endfunction

  // walks the table in order against a copy of memory taken after reset
  function automatic void compute_expected();
    word_t      shadow [16];
    word_t      raw;
    word_t      keep;    // bits that hold loaded data
    logic [3:0] widx;
    int         off;
    int         nbytes;
    int         k;
    shadow = lsu_tb_mem_inst.mem_q;
    for (int i = 0; i < n_tab; i++)
    begin
      tab[i].exp_addr = tab[i].use_incr ? tab[i].op_a + tab[i].op_b : tab[i].op_a;
      off    = int'(tab[i].exp_addr[1:0]);
      widx   = tab[i].exp_addr[5:2];
      nbytes = (tab[i].size == SIZE_WORD) ? 4 : (tab[i].size == SIZE_HALF) ? 2 : 1;
      keep   = (nbytes == 4) ? 32'hffff_ffff : (nbytes == 2) ? 32'h0000_ffff : 32'h0000_00ff;
      for (int l = 0; l < 4; l++)
      begin
        k = (l - off) & 3;  // store byte that lands in lane l
        tab[i].exp_wdata[8*l +: 8] = tab[i].wdata[8*k +: 8];
        tab[i].exp_be[l] = (k < nbytes);
        if (tab[i].we && tab[i].exp_be[l])
          shadow[widx][8*l +: 8] = tab[i].exp_wdata[8*l +: 8];
      end
      raw = shadow[widx] >> (8 * off);
      tab[i].exp_rdata = raw & keep;
      if (tab[i].ext == EXT_ONES || (tab[i].ext == EXT_SIGN && raw[8*nbytes-1]))
        tab[i].exp_rdata = tab[i].exp_rdata | ~keep;
    end
  endfunction

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  function automatic void count_error(int idx);
    errors++;
    if (idx >= 0)
      err_entry[idx]++;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp, input int idx);
    if (got !== exp)
    begin
      $display("FAILED %s: got %08h, expected %08h", name, got, exp);
      count_error(idx);
    end
  endtask

  task automatic check_be(input string name, input be_t got, input be_t exp, input int idx);
    if (got !== exp)
    begin
      $display("FAILED %s: got %0h, expected %0h", name, got, exp);
      count_error(idx);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp, input int idx);
    if (got !== exp)
    begin
      $display("FAILED %s: got %0h, expected %0h", name, got, exp);
      count_error(idx);
    end
  endtask

  //////////////////////////////////////////////////
  // bus and response monitor sampled mid cycle
  //////////////////////////////////////////////////

  always @(negedge clk)
  begin
    int idx;
    if (rst_n && running)
    begin
      if (out_cnt > 2)
      begin
        $display("more than two transfers were outstanding on the bus");
        count_error(cur);
      end
      if (out_cnt != 0)
        check_bit("busy_o", busy, 1'b1, cur);
      if (hold_q && data_req)  // payload frozen while waiting for grant
      begin
        check_word("data_o.addr (held)", data.addr, held.addr, cur);
        check_bit("data_o.we (held)", data.we, held.we, cur);
        check_word("data_o.wdata (held)", data.wdata, held.wdata, cur);
        check_be("data_o.be (held)", data.be, held.be, cur);
      end
      if (data_req && gnt)
      begin
        check_word("data_o.addr", data.addr, tab[cur].exp_addr, cur);
        check_bit("data_o.we", data.we, tab[cur].we, cur);
        check_be("data_o.be", data.be, tab[cur].exp_be, cur);
        if (tab[cur].we)
          check_word("data_o.wdata", data.wdata, tab[cur].exp_wdata, cur);
        pend_q.push_back(cur);
        out_cnt++;
        granted_idx = cur;
      end
      if (rvalid && pend_q.size() == 0)
      begin
        $display("response arrived with no transfer outstanding");
        count_error(cur);
      end
      else if (rvalid)
      begin
        idx = pend_q.pop_front();
        out_cnt--;
        check_bit("ready_wb_o", ready_wb, 1'b1, idx);
        if (!tab[idx].we)
        begin
          check_word("rdata_o", rdata, tab[idx].exp_rdata, idx);
          have_load = 1'b1;
          last_load = tab[idx].exp_rdata;
          last_idx  = idx;
        end
        if (err_entry[idx] == 0)
        begin
          $display("entry %0d (%s) ok", idx, tab[idx].we ? "store" : "load");
          n_pass++;
        end
        else
        begin
          $display("entry %0d (%s) saw %0d errors", idx, tab[idx].we ? "store" : "load",
                   err_entry[idx]);
          n_fail++;
        end
      end
      else if (have_load)
      begin
        check_word("rdata_o (held)", rdata, last_load, last_idx);
      end
      // execute lets go once granted, with one transfer left in writeback
      check_bit("ready_ex_o", ready_ex,
                !req_valid || (granted_idx == cur && out_cnt == 1), cur);
      hold_q = data_req && !gnt;
      held   = data;
    end
  end

  // 40 cycles per table entry
  initial
  begin
    #(CLK_PERIOD * 40 * N_ENTRIES);
    $display("watchdog expired, run did not finish within %0d cycles", 40 * N_ENTRIES);
    $display("Test failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial
  begin
    int errs_before;
    void'($urandom(32'h4d2e));
    clk         = 1'b0;
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req         = '0;
    running     = 1'b0;
    hold_q      = 1'b0;
    have_load   = 1'b0;
    granted_idx = -1;
    // stores of every size at every legal offset
    add_entry(1'b1, SIZE_WORD, EXT_ZERO, 1'b0, 32'h10, 32'h0,  32'h1122_3344);
    add_entry(1'b1, SIZE_HALF, EXT_ZERO, 1'b1, 32'h1c, 32'h4,  32'hdead_8a5c);
    add_entry(1'b1, SIZE_HALF, EXT_ZERO, 1'b0, 32'h22, 32'h55, 32'h7b1e_f00d);
    add_entry(1'b1, SIZE_BYTE, EXT_ZERO, 1'b1, 32'h30, 32'h0,  32'h37c8_e985);
    add_entry(1'b1, SIZE_BYTE, EXT_ZERO, 1'b1, 32'h30, 32'h1,  32'h9c3d_5a12);
    add_entry(1'b1, SIZE_BYTE, EXT_ZERO, 1'b1, 32'h2f, 32'h3,  32'h6e4f_21f3);
    add_entry(1'b1, SIZE_BYTE, EXT_ZERO, 1'b0, 32'h33, 32'h7,  32'ha1b2_c37e);
    // loads back with every fill rule
    add_entry(1'b0, SIZE_WORD, EXT_ZERO, 1'b1, 32'h08, 32'h8,  32'h0);
    add_entry(1'b0, SIZE_HALF, EXT_ZERO, 1'b0, 32'h20, 32'h0,  32'h0);
    add_entry(1'b0, SIZE_HALF, EXT_SIGN, 1'b0, 32'h20, 32'h0,  32'h0);
    add_entry(1'b0, SIZE_HALF, EXT_ONES, 1'b1, 32'h20, 32'h2,  32'h0);
    add_entry(1'b0, SIZE_HALF, EXT_SIGN, 1'b0, 32'h22, 32'h9,  32'h0);
    add_entry(1'b0, SIZE_BYTE, EXT_SIGN, 1'b0, 32'h30, 32'h0,  32'h0);
    add_entry(1'b0, SIZE_BYTE, EXT_ZERO, 1'b1, 32'h2d, 32'h4,  32'h0);
    add_entry(1'b0, SIZE_BYTE, EXT_ONES, 1'b0, 32'h32, 32'h0,  32'h0);
    add_entry(1'b0, SIZE_BYTE, EXT_SIGN, 1'b0, 32'h33, 32'h0,  32'h0);
    add_entry(1'b0, SIZE_WORD, EXT_ZERO, 1'b0, 32'h04, 32'h1234, 32'h0);  // untouched word
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    errs_before = errors;
    check_bit("busy_o", busy, 1'b0, -1);
    check_bit("ready_wb_o", ready_wb, 1'b1, -1);
    check_bit("data_req_o", data_req, 1'b0, -1);
    if (errors == errs_before)
      n_pass++;
    else
      n_fail++;
    $display("reset state %s", (errors == errs_before) ? "ok" : "wrong");
    compute_expected();
    running = 1'b1;
    for (int i = 0; i < n_tab; i++)
    begin
      @(posedge clk);
      cur = i;
      req_valid <= 1'b1;
      req <= {tab[i].we, tab[i].size, tab[i].ext, tab[i].use_incr,
              tab[i].op_a, tab[i].op_b, tab[i].wdata};
      @(negedge clk);
      while (!ready_ex)  // consumed on the next rising edge
        @(negedge clk);
    end
    @(posedge clk);
    req_valid <= 1'b0;
    @(negedge clk);
    while (pend_q.size() != 0 || busy)
      @(negedge clk);
    @(negedge clk);
    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             n_pass + n_fail, n_pass, n_fail, errors);
    if (errors == 0 && n_pass == n_tab + 1)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== files.f ====
src/lsu_pkg.sv
src/lsu_store_align.sv
src/lsu_load_align.sv
src/lsu_txn_ctrl.sv
src/lsu_top.sv
dv/lsu_tb_mem.sv
dv/lsu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = lsu_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: sim clean

# build, run, and fail unless the pass message shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
